/* hw/print_pkg.sv */
package print_pkg;

    // register map, byte offsets on the 4-bit AXI address
    localparam logic [3:0] REG_BYTE   = 4'h0;  // write: print low byte raw
    localparam logic [3:0] REG_WORD   = 4'h4;  // write: print word as hex
    localparam logic [3:0] REG_STATUS = 4'h8;  // read: busy and sent count

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // UART timing, kept short so simulation runs fast
    localparam int CLKS_PER_BIT = 4;
    localparam int BAUD_W       = $clog2(CLKS_PER_BIT);  // baud counter width

    // word print is XXXX_XXXX
    localparam int         WORD_CHARS = 9;
    localparam logic [7:0] UNDERSCORE = 8'h5F;  // '_'

    typedef enum logic {
        KIND_BYTE,  // one raw character
        KIND_WORD   // nine hex characters
    } print_kind_e;

    typedef enum logic [1:0] {
        FMT_IDLE,  // waiting for start
        FMT_EMIT,  // load next character
        FMT_WAIT   // character offered, waiting for rdy
    } fmt_state_e;

endpackage

/* hw/char_stream_if.sv */
`timescale 1ns/1ps

interface char_stream_if;
    logic       vld;   // character offered
    logic       rdy;   // transmitter idle
    logic [7:0] data;  // ASCII or raw byte
    logic       last;  // final character of a print

    modport source (
        output vld,
        output data,
        output last,
        input  rdy
    );

    modport sink (
        input  vld,
        input  data,
        input  last,
        output rdy
    );
endinterface

/* hw/print_regs.sv */
`timescale 1ns/1ps

module print_regs import print_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    // write address and data
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    // write response
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    // read address and data
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    // formatter side
    output logic        start,
    output print_kind_e kind,
    output logic [31:0] value,
    input  logic        done,
    input  logic [15:0] sent_count
);

    logic        wr_hs;    // address and data accepted this cycle
    logic        rd_hs;    // read address accepted this cycle
    logic        busy;     // a print is in progress
    logic        wr_ok;    // decoded write may start a print
    print_kind_e wr_kind;  // kind selected by the write offset

    assign wr_hs = awvalid && awready && wvalid && wready;
    assign rd_hs = arvalid && arready;

    // wstrb is not decoded, so a partial write still prints the full word
    always_comb begin
        wr_ok   = 1'b0;
        wr_kind = KIND_BYTE;
        case (awaddr)
            REG_BYTE: begin
                wr_ok   = !busy;
                wr_kind = KIND_BYTE;
            end
            REG_WORD: begin
                wr_ok   = !busy;
                wr_kind = KIND_WORD;
            end
            default: wr_ok = 1'b0;  // status and unmapped offsets
        endcase
    end

    // both ready lines pulse together, once per write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            awready <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !awready && !bvalid;
        end
    end

    assign wready = awready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid <= 1'b0;
            start  <= 1'b0;
            busy   <= 1'b0;
        end else begin
            start <= wr_hs && wr_ok;  // one-cycle pulse
            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (wr_hs && wr_ok) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    // response and print arguments
    always_ff @(posedge clk) begin
        if (wr_hs) begin
            bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
            if (wr_ok) begin
                kind  <= wr_kind;
                value <= wdata;  // held until the next accepted print
            end
        end
    end

    // read channel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            if (araddr == REG_STATUS) begin
                rdata <= {sent_count, 15'd0, busy};
                rresp <= RESP_OKAY;
            end else begin
                rdata <= 32'd0;
                rresp <= RESP_SLVERR;
            end
        end
    end

endmodule

/* hw/print_formatter.sv */
`timescale 1ns/1ps

module print_formatter import print_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  print_kind_e   kind,
    input  logic [31:0]   value,
    output logic          done,
    char_stream_if.source chars
);

    fmt_state_e state;
    logic [3:0] idx;  // index of the character on the stream

    // nibble to upper-case ASCII hex
    function automatic logic [7:0] hex_ascii(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return 8'h30 + {4'h0, nib};
        end
        return 8'h41 + {4'h0, nib} - 8'd10;
    endfunction

    // character at position i of a print
    function automatic logic [7:0] char_at(input print_kind_e k, input logic [31:0] v,
                                           input logic [3:0] i);
        logic [2:0] nib_pos;
        logic [3:0] nib;
        if (k == KIND_BYTE) begin
            return v[7:0];
        end
        if (i == 4'd4) begin
            return UNDERSCORE;
        end
        nib_pos = (i < 4'd4) ? 3'(4'd7 - i) : 3'(4'd8 - i);  // msb nibble first
        nib     = v[{nib_pos, 2'b00} +: 4];
        return hex_ascii(nib);
    endfunction

    function automatic logic is_last(input print_kind_e k, input logic [3:0] i);
        return (k == KIND_BYTE) || (i == 4'(WORD_CHARS - 1));
    endfunction

    // value and kind stay stable in print_regs while busy
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= FMT_IDLE;
            idx       <= 4'd0;
            chars.vld <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                FMT_IDLE: begin
                    if (start) begin
                        idx       <= 4'd0;
                        chars.vld <= 1'b1;  // first character right away
                        state     <= FMT_WAIT;
                    end
                end
                FMT_EMIT: begin
                    chars.vld <= 1'b1;
                    state     <= FMT_WAIT;
                end
                FMT_WAIT: begin
                    if (chars.rdy) begin
                        chars.vld <= 1'b0;
                        if (chars.last) begin
                            done  <= 1'b1;
                            state <= FMT_IDLE;
                        end else begin
                            idx   <= idx + 4'd1;
                            state <= FMT_EMIT;
                        end
                    end
                end
                default: state <= FMT_IDLE;
            endcase
        end
    end

    // character payload, loaded as the character is offered
    always_ff @(posedge clk) begin
        if (state == FMT_IDLE && start) begin
            chars.data <= char_at(kind, value, 4'd0);
            chars.last <= is_last(kind, 4'd0);
        end else if (state == FMT_EMIT) begin
            chars.data <= char_at(kind, value, idx);
            chars.last <= is_last(kind, idx);
        end
    end

endmodule

/* hw/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx import print_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    char_stream_if.sink chars,
    output logic        tx,
    output logic [15:0] sent_count
);

    logic              active;    // frame on the line
    logic [BAUD_W-1:0] baud_cnt;  // clocks within the current bit
    logic [3:0]        bit_cnt;   // 0 start, 1..8 data, 9 stop
    logic [8:0]        shreg;     // data bits then stop bit
    logic              accept;

    assign chars.rdy = !active;
    assign accept    = chars.vld && chars.rdy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx         <= 1'b1;  // line idles high
            active     <= 1'b0;
            baud_cnt   <= '0;
            bit_cnt    <= 4'd0;
            sent_count <= 16'd0;
        end else if (accept) begin
            tx         <= 1'b0;  // start bit
            active     <= 1'b1;
            baud_cnt   <= '0;
            bit_cnt    <= 4'd0;
            sent_count <= sent_count + 16'd1;  // wraps
        end else if (active) begin
            if (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1)) begin
                baud_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    active <= 1'b0;  // stop bit finished
                end else begin
                    tx      <= shreg[0];
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    // lsb first, stop bit shifts in behind the data
    always_ff @(posedge clk) begin
        if (accept) begin
            shreg <= {1'b1, chars.data};
        end else if (active && baud_cnt == BAUD_W'(CLKS_PER_BIT - 1)) begin
            shreg <= {1'b1, shreg[8:1]};
        end
    end

endmodule

/* hw/debug_print_top.sv */
`timescale 1ns/1ps

module debug_print_top import print_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    output logic        tx
);

    logic        start;
    print_kind_e kind;
    logic [31:0] value;
    logic        done;
    logic [15:0] sent_count;

    char_stream_if chars ();  // formatter to transmitter

    print_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .start      (start),
        .kind       (kind),
        .value      (value),
        .done       (done),
        .sent_count (sent_count)
    );

    print_formatter u_fmt (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .kind  (kind),
        .value (value),
        .done  (done),
        .chars (chars.source)
    );

    uart_tx u_tx (
        .clk        (clk),
        .rst        (rst),
        .chars      (chars.sink),
        .tx         (tx),
        .sent_count (sent_count)
    );

endmodule

/* sim/debug_print_properties.sv */
`timescale 1ns/1ps

module debug_print_properties import print_pkg::*; (
    input logic        clk, rst, tx,
    input logic        bvalid, bready, rvalid, rready,
    input logic        start, done, vld, rdy, last,
    input print_kind_e kind,
    input logic [7:0]  data
);

    logic [3:0] xfers;     // stream transfers since the last start
    logic       word_run;  // current print is a word print

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            xfers    <= 4'd0;
            word_run <= 1'b0;
        end else if (start) begin
            xfers    <= 4'd0;
            word_run <= (kind == KIND_WORD);  // kind is valid alongside start
        end else if (vld && rdy) begin
            xfers <= xfers + 4'd1;
        end
    end

    assert property (@(posedge clk) rst |-> tx)
        else $error("tx left its idle level during reset");
    assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");
    assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");
    // a stalled character must not change under the transmitter
    assert property (@(posedge clk) disable iff (rst)
        vld && !rdy |=> vld && $stable(data) && $stable(last))
        else $error("stream character changed while stalled");
    assert property (@(posedge clk) disable iff (rst) done && word_run |-> xfers == 4'(WORD_CHARS))
        else $error("word print finished with the wrong number of characters");

endmodule

bind debug_print_top debug_print_properties props (
    .clk, .rst, .tx, .bvalid, .bready, .rvalid, .rready, .start, .kind, .done,
    .vld  (chars.vld),
    .rdy  (chars.rdy),
    .data (chars.data),
    .last (chars.last)
);

/* sim/debug_print_tb.sv */
`timescale 1ns/1ps

module debug_print_tb import print_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 6000;  // about 12 nine-character prints plus bus time and margin

    logic        clk;
    logic        rst;
    logic [3:0]  awaddr, araddr, wstrb;
    logic [31:0] wdata, rdata;
    logic [1:0]  bresp, rresp;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready, tx;

    logic [7:0]  exp_q[$];  // characters still due on tx
    logic [31:0] rnd;
    logic [31:0] rd_data;
    int          seed;
    int          error_count;
    int          rx_count;  // characters seen by the line decoder
    int          cycle_count;

    debug_print_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else begin
            $display("FAIL at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
            error_count++;
        end
    endtask

    // address and data go out together and bready waits hold cycles
    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int hold, input logic [1:0] exp_resp);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        check_field("wready", 32'd1, 32'(wready));
        @(negedge clk);  // accepted on the rising edge just passed
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        repeat (hold) @(negedge clk);
        check_field("bresp", 32'(exp_resp), 32'(bresp));
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] addr, input int hold, input logic [1:0] exp_resp,
                            output logic [31:0] data);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        repeat (hold) @(negedge clk);
        check_field("rresp", 32'(exp_resp), 32'(rresp));
        data   = rdata;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    function automatic logic [7:0] hex_char(input logic [3:0] nib);
        return (nib < 4'd10) ? 8'h30 + 8'(nib) : 8'h37 + 8'(nib);  // '0'..'9', 'A'..'F'
    endfunction

    // XXXX_XXXX with the most significant nibble first
    task automatic expect_word(input logic [31:0] v);
        for (int i = 7; i >= 0; i--) begin
            if (i == 3) begin
                exp_q.push_back(UNDERSCORE);
            end
            exp_q.push_back(hex_char(v[i*4 +: 4]));
        end
    endtask

    task automatic wait_printed();
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    // busy clear and the count matches what the decoder saw
    task automatic check_idle(input int hold);
        read_reg(REG_STATUS, hold, RESP_OKAY, rd_data);
        check_field("status", {16'(rx_count), 16'd0}, rd_data);
    endtask

    // 8N1 line decoder sampling near the middle of each bit
    initial begin : line_decoder
        logic [7:0] ch;
        forever begin
            @(negedge tx);
            repeat (CLKS_PER_BIT / 2 + 1) @(negedge clk);
            assert (tx === 1'b0) else begin
                $display("error at %0t ns: start bit on tx did not stay low", $time);
                error_count++;
            end
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                ch[i] = tx;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            assert (tx === 1'b1) else begin
                $display("error at %0t ns: missing stop bit on tx", $time);
                error_count++;
            end
            rx_count++;
            assert (exp_q.size() != 0) else begin
                $display("error at %0t ns: unexpected character 0x%0h on tx", $time, ch);
                error_count++;
            end
            if (exp_q.size() != 0) begin
                check_field("tx character", 32'(exp_q.pop_front()), 32'(ch));
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the prints did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        seed = 32'h79519bbe;
        rst  = 1'b1;
        {awaddr, araddr, wstrb, wdata} = '0;
        {awvalid, wvalid, bready, arvalid, rready} = '0;
        error_count = 0;
        rx_count    = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        repeat (8) begin
            @(negedge clk);
            check_field("tx", 32'd1, 32'(tx));
        end
        check_idle(0);

        exp_q.push_back(8'h4B);  // upper bits of wdata must not matter
        write_reg(REG_BYTE, 32'hA5C3_004B, 4'hF, 0, RESP_OKAY);
        wait_printed();
        rnd = $random(seed);
        exp_q.push_back(rnd[7:0]);
        write_reg(REG_BYTE, rnd, 4'hF, 0, RESP_OKAY);
        wait_printed();
        check_idle(0);

        for (int n = 0; n < 4; n++) begin
            rnd = $random(seed);
            expect_word(rnd);
            write_reg(REG_WORD, rnd, (n == 2) ? 4'b0011 : 4'hF, 0, RESP_OKAY);
            wait_printed();
        end
        check_idle(0);

        // second and third writes land while the word is still printing
        rnd = $random(seed);
        expect_word(rnd);
        write_reg(REG_WORD, rnd, 4'hF, 0, RESP_OKAY);
        write_reg(REG_BYTE, 32'h0000_0021, 4'hF, 0, RESP_SLVERR);
        write_reg(REG_WORD, ~rnd, 4'hF, 0, RESP_SLVERR);
        read_reg(REG_STATUS, 0, RESP_OKAY, rd_data);
        check_field("status busy", 32'd1, 32'(rd_data[0]));
        wait_printed();
        check_idle(0);

        write_reg(REG_STATUS, 32'hFFFF_FFFF, 4'hF, 0, RESP_SLVERR);
        write_reg(4'hC, 32'h0000_0041, 4'hF, 0, RESP_SLVERR);
        read_reg(4'hC, 0, RESP_SLVERR, rd_data);
        check_field("rdata", 32'd0, rd_data);

        // slow master whose responses wait for bready and rready
        rnd = $random(seed);
        expect_word(rnd);
        write_reg(REG_WORD, rnd, 4'hF, 6, RESP_OKAY);
        read_reg(REG_STATUS, 7, RESP_OKAY, rd_data);
        check_field("status busy", 32'd1, 32'(rd_data[0]));
        wait_printed();
        exp_q.push_back(8'h7E);
        write_reg(REG_BYTE, 32'h0000_007E, 4'hF, 3, RESP_OKAY);
        wait_printed();
        check_idle(5);
        repeat (60) @(negedge clk);  // room for a stray character to show up

        $display("summary: %0d errors, %0d characters received", error_count, rx_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* debug_print.f */
hw/print_pkg.sv
hw/char_stream_if.sv
hw/print_regs.sv
hw/print_formatter.sv
hw/uart_tx.sv
hw/debug_print_top.sv
sim/debug_print_properties.sv
sim/debug_print_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module debug_print_tb -Mdir obj_dir -f debug_print.f
	./obj_dir/Vdebug_print_tb > sim.log 2>&1 || (cat sim.log; false)
	cat sim.log
	! grep -q "TESTS FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
